/* dv/int_cluster_checks.svh */
`ifndef INT_CLUSTER_CHECKS_SVH
`define INT_CLUSTER_CHECKS_SVH

// error counters for the closing report
int mismatch_count = 0;
int other_count    = 0;

task automatic note_failure(input string what);
    other_count++;
    $display("ERROR at %0t: %s", $time, what);
endtask

// one retire slot against its expected contents
task automatic check_entry(input cluster_pkg::retire_entry_t got,
                           input cluster_pkg::retire_entry_t want,
                           input string name);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
        // field view, easier to read than the packed word
        $display("  got rd %0d tag %h value %h, expected rd %0d tag %h value %h",
                 got.rd, got.tag, got.value, want.rd, want.tag, want.value);
    end
endtask

// one data word, used for the debug port
task automatic check_word(input logic [isa_pkg::xlen-1:0] got,
                          input logic [isa_pkg::xlen-1:0] want,
                          input string name);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
    end
endtask

`endif

/* dv/int_cluster_tb.sv */
module int_cluster_tb;

    localparam int LANES     = 2;
    localparam int MAX_TESTS = 64;

    logic                                       clk;
    logic                                       arst_n;
    logic                                       in_valid;
    cluster_pkg::in_req_t                       in_req;
    logic                                       in_ready;
    logic                                       retire_valid;
    cluster_pkg::retire_entry_t [LANES-1:0]     retire;
    logic                                       retire_ready;
    isa_pkg::reg_idx_t                          dbg_addr;
    logic [isa_pkg::xlen-1:0]                   dbg_data;

    // three slots per test: word, tag, expected value
    logic [31:0]                tests_mem [0:MAX_TESTS*3-1];
    logic [isa_pkg::xlen-1:0]   model_regs [0:31];
    logic [isa_pkg::xlen-1:0]   exp_val [0:255];
    isa_pkg::reg_idx_t          exp_rd [0:255];
    logic                       tag_known [0:255];
    logic                       tag_seen [0:255];
    int                         n_tests = 0;
    int                         retired = 0;
    int                         cycles = 0;
    int                         cycle_limit = 100;
    logic                       multi_seen = 1'b0;
    logic [31:0]                rng_in;
    logic [31:0]                rng_ret;

    `include "int_cluster_checks.svh"

    int_cluster UUT (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_req(in_req), .in_ready(in_ready),
        .retire_valid(retire_valid), .retire(retire), .retire_ready(retire_ready),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference ALU, wraps modulo 2^32
    function automatic logic [31:0] model_result(input isa_pkg::opcode_t op,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (op)
            isa_pkg::ADD, isa_pkg::ADDI: return a + b;
            isa_pkg::SUB:                return a - b;
            isa_pkg::AND:                return a & b;
            isa_pkg::OR:                 return a | b;
            isa_pkg::XOR, isa_pkg::XORI: return a ^ b;
            isa_pkg::SHL:                return a << b[4:0];
            isa_pkg::SHR:                return a >> b[4:0];
            default:                     return 32'h0;
        endcase
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic load_tests();
        for (int i = 0; i < MAX_TESTS * 3; i++) begin
            // opcode nibble f never occurs in a real word
            tests_mem[i] = {4'hf, 28'(i)};
        end
        $readmemh("dv/int_cluster_tests.txt", tests_mem);
        while (n_tests < MAX_TESTS && tests_mem[3*n_tests][31:28] != 4'hf) begin
            n_tests++;
        end
        if (n_tests == 0) begin
            note_failure("no tests were read from dv/int_cluster_tests.txt");
        end
        cycle_limit = n_tests * 20 + 100;
    endtask

    // walk the program in order and predict every tag
    task automatic build_model();
        isa_pkg::instr_u     w;
        cluster_pkg::tag_t   t;
        logic [31:0]         b;
        logic [31:0]         v;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            tag_known[i] = 1'b0;
            tag_seen[i]  = 1'b0;
        end
        for (int k = 0; k < n_tests; k++) begin
            w = isa_pkg::instr_u'(tests_mem[3*k]);
            t = cluster_pkg::tag_t'(tests_mem[3*k+1]);
            if (w.r.opcode == isa_pkg::ADDI || w.r.opcode == isa_pkg::XORI) begin
                b = {{14{w.i.imm[17]}}, w.i.imm};
            end else begin
                b = model_regs[w.r.rs2];
            end
            v = model_result(w.r.opcode, model_regs[w.r.rs1], b);
            if (v !== tests_mem[3*k+2]) begin
                note_failure($sformatf("tests file gives %h for tag %h, reference model gives %h",
                                       tests_mem[3*k+2], t, v));
            end
            if (tag_known[t]) begin
                note_failure($sformatf("tag %h appears twice in the tests file", t));
            end
            tag_known[t]       = 1'b1;
            exp_rd[t]          = w.r.rd;
            exp_val[t]         = v;
            model_regs[w.r.rd] = v;
        end
    endtask

    task automatic drive_inputs();
        int k;
        int gap;
        k = 0;
        while (k < n_tests) begin
            @(negedge clk);
            rng_in = xorshift(rng_in);
            // idle cycle after the first pair so lane 0 fills and lane 1 gets work
            if (k == 2) begin
                gap = 1;
            end else if (k >= 4 && rng_in[2:0] == 3'd0) begin
                gap = 1 + int'(rng_in[4:3]);
            end else begin
                gap = 0;
            end
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            in_valid     = 1'b1;
            in_req.instr = isa_pkg::instr_u'(tests_mem[3*k]);
            in_req.tag   = cluster_pkg::tag_t'(tests_mem[3*k+1]);
            #1;
            while (!in_ready) begin
                @(negedge clk);
                #1;
            end
            @(posedge clk);
            k++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic accept_bundle();
        int                          n_valid;
        cluster_pkg::tag_t           t;
        cluster_pkg::retire_entry_t  want;
        n_valid = 0;
        for (int i = 0; i < LANES; i++) begin
            if (retire[i].valid) begin
                n_valid++;
                t = retire[i].tag;
                if (!tag_known[t]) begin
                    note_failure($sformatf("retire[%0d] carries unknown tag %h", i, t));
                end else if (tag_seen[t]) begin
                    note_failure($sformatf("tag %h retired a second time", t));
                end else begin
                    want = '{valid: 1'b1, rd: exp_rd[t], tag: t, value: exp_val[t]};
                    check_entry(retire[i], want, $sformatf("retire[%0d]", i));
                end
                tag_seen[t] = 1'b1;
                retired++;
            end
        end
        if (n_valid > 1) begin
            multi_seen = 1'b1;
        end
    endtask

    task automatic drain_retires();
        cluster_pkg::retire_entry_t [LANES-1:0]  held;
        logic                                    stalled;
        int                                      c;
        stalled = 1'b0;
        held    = '0;
        c       = 0;
        while (retired < n_tests) begin
            @(negedge clk);
            rng_ret = xorshift(rng_ret);
            // no retire at first, so both lanes end up holding results
            retire_ready = (c >= 8) && (rng_ret[1:0] != 2'd0);
            c++;
            #1;
            if (stalled) begin
                // an empty slot may fill, an offered one must not move
                for (int i = 0; i < LANES; i++) begin
                    if (held[i].valid) begin
                        check_entry(retire[i], held[i],
                                    $sformatf("retire[%0d] while stalled", i));
                    end
                end
            end
            if (retire_valid && retire_ready) begin
                accept_bundle();
                stalled = 1'b0;
            end else begin
                stalled = retire_valid;
                held    = retire;
            end
        end
        @(negedge clk);
        retire_ready = 1'b0;
    endtask

    task automatic check_final_state();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            dbg_addr = isa_pkg::reg_idx_t'(r);
            #1;
            check_word(dbg_data, model_regs[r], $sformatf("dbg_data (r%0d)", r));
        end
        if (retire_valid) begin
            note_failure("a result was offered after every tag had retired");
        end
        for (int t = 0; t < 256; t++) begin
            if (tag_known[t] && !tag_seen[t]) begin
                note_failure($sformatf("tag %h never retired", t));
            end
        end
        if (!multi_seen) begin
            note_failure("no retire bundle ever held more than one valid entry");
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            note_failure($sformatf("timeout after %0d cycles, %0d of %0d tags retired",
                                   cycles, retired, n_tests));
            finish_run();
        end
    end

    initial begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_req       = '0;
        retire_ready = 1'b0;
        dbg_addr     = '0;
        rng_in       = 32'he85260d3;
        rng_ret      = xorshift(32'he85260d3);
        load_tests();
        build_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fork
            drive_inputs();
            drain_retires();
        join
        check_final_state();
        finish_run();
    end

endmodule

/* dv/int_cluster_tests.txt */
// columns: instruction word, tag, expected rd value (all hex)
// word fields: opcode[31:28] rd[27:23] rs1[22:18] then rs2[17:13] or imm[17:0]
70800005 10 00000005
71000003 11 00000003
7183ffff 12 ffffffff
72000100 13 00000100
02844000 14 00000008
13082000 15 fffffffe
238c8000 16 00000100
34048000 17 00000105
448c2000 18 fffffffa
55048000 19 00000005
55844000 1a 00000028
660c4000 1b 1fffffff
// chain on r1, each step waits for the previous write
00842000 1c 0000000a
00842000 1d 00000014
1684a000 1e 0000000c
// same low 18 bits as register form and as immediate form
470aa000 1f 00000003
878aa000 20 fffea003
0812a000 21 00000100
7892a000 22 fffea100
713dffff 23 0000a002
69444000 24 3fffa840
39c9a000 25 3fffa84c
1a026000 26 c00057b4
8a51ffff 27 c001a84b
2b506000 28 c001a84b
0086c000 29 c001a85f

/* int_cluster.f */
+incdir+dv
logic/isa_pkg.sv
logic/cluster_pkg.sv
logic/regfile.sv
logic/issue_unit.sv
logic/alu_lane.sv
logic/writeback_unit.sv
logic/int_cluster.sv
dv/int_cluster_tb.sv

/* logic/alu_lane.sv */
module alu_lane (
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic                          disp_valid,
    input  cluster_pkg::dispatch_t        disp,
    output logic                          disp_ready,

    output logic                          res_valid,
    output cluster_pkg::lane_result_t     res,
    input  logic                          res_ready
);

    logic                         s1_valid;
    logic                         s2_valid;
    cluster_pkg::lane_result_t    s1;
    cluster_pkg::lane_result_t    s2;
    logic                         take;
    logic                         s2_free;
    logic                         s1_adv;

    // full only when both stages hold something
    assign disp_ready = !(s1_valid && s2_valid);
    assign take       = disp_valid && disp_ready;

    assign s2_free = !s2_valid || res_ready;
    assign s1_adv  = s1_valid && s2_free;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (take) begin
                s1_valid <= 1'b1;
            end else if (s1_adv) begin
                s1_valid <= 1'b0;
            end

            if (s1_adv) begin
                s2_valid <= 1'b1;
            end else if (res_ready) begin
                s2_valid <= 1'b0;
            end
        end
    end

    // stage 1 computes
    always_ff @(posedge clk) begin
        if (take) begin
            s1.rd    <= disp.rd;
            s1.tag   <= disp.tag;
            s1.value <= isa_pkg::alu_eval(disp.op, disp.a, disp.b);
        end
    end

    // stage 2 holds for writeback
    always_ff @(posedge clk) begin
        if (s1_adv) begin
            s2 <= s1;
        end
    end

    assign res_valid = s2_valid;
    assign res       = s2;

    // an offered dispatch stays put until this lane takes it
    a_disp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        disp_valid && !disp_ready |=> disp_valid && $stable(disp));

endmodule

/* logic/cluster_pkg.sv */
package cluster_pkg;

    typedef logic [7:0] tag_t;

    // one word from the input stream
    typedef struct packed {
        isa_pkg::instr_u instr;
        tag_t            tag;
    } in_req_t;

    // operands already read, b holds the extended immediate for i-forms
    typedef struct packed {
        isa_pkg::opcode_t          op;
        isa_pkg::reg_idx_t         rd;
        tag_t                      tag;
        logic [isa_pkg::xlen-1:0]  a;
        logic [isa_pkg::xlen-1:0]  b;
    } dispatch_t;

    // what a lane hands to writeback
    typedef struct packed {
        isa_pkg::reg_idx_t         rd;
        tag_t                      tag;
        logic [isa_pkg::xlen-1:0]  value;
    } lane_result_t;

    // one slot of the retire bundle, slot i belongs to lane i
    typedef struct packed {
        logic                      valid;
        isa_pkg::reg_idx_t         rd;
        tag_t                      tag;
        logic [isa_pkg::xlen-1:0]  value;
    } retire_entry_t;

endpackage

/* logic/int_cluster.sv */
module int_cluster #(
    parameter int NUM_LANES = 2,
    parameter int NUM_REGS  = 32
) (
    input  logic                                         clk,
    input  logic                                         arst_n,

    input  logic                                         in_valid,
    input  cluster_pkg::in_req_t                         in_req,
    output logic                                         in_ready,

    output logic                                         retire_valid,
    output cluster_pkg::retire_entry_t [NUM_LANES-1:0]   retire,
    input  logic                                         retire_ready,

    input  isa_pkg::reg_idx_t                            dbg_addr,
    output logic [isa_pkg::xlen-1:0]                     dbg_data
);

    isa_pkg::reg_idx_t [1:0]                      rs_addr;
    logic [1:0][isa_pkg::xlen-1:0]                rs_data;
    logic [NUM_LANES-1:0]                         disp_valid;
    logic [NUM_LANES-1:0]                         disp_ready;
    cluster_pkg::dispatch_t                       disp;
    logic [NUM_LANES-1:0]                         res_valid;
    logic [NUM_LANES-1:0]                         res_ready;
    cluster_pkg::lane_result_t [NUM_LANES-1:0]    res;
    logic [NUM_LANES-1:0]                         wr_en;
    isa_pkg::reg_idx_t [NUM_LANES-1:0]            wr_addr;
    logic [NUM_LANES-1:0][isa_pkg::xlen-1:0]      wr_data;
    logic [NUM_REGS-1:0]                          clear_mask;
    // ports 0 and 1 for operands, port 2 for debug
    isa_pkg::reg_idx_t [2:0]                      rf_rd_addr;
    logic [2:0][isa_pkg::xlen-1:0]                rf_rd_data;

    assign rf_rd_addr = {dbg_addr, rs_addr[1], rs_addr[0]};
    assign rs_data    = {rf_rd_data[1], rf_rd_data[0]};
    assign dbg_data   = rf_rd_data[2];

    issue_unit #(.NUM_LANES(NUM_LANES), .NUM_REGS(NUM_REGS)) u_issue (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_req(in_req), .in_ready(in_ready),
        .rs_addr(rs_addr), .rs_data(rs_data),
        .disp_valid(disp_valid), .disp(disp), .disp_ready(disp_ready),
        .clear_mask(clear_mask)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk(clk), .arst_n(arst_n),
            .disp_valid(disp_valid[i]), .disp(disp), .disp_ready(disp_ready[i]),
            .res_valid(res_valid[i]), .res(res[i]), .res_ready(res_ready[i])
        );
    end

    writeback_unit #(.NUM_LANES(NUM_LANES), .NUM_REGS(NUM_REGS)) u_wb (
        .clk(clk), .arst_n(arst_n),
        .res_valid(res_valid), .res(res), .res_ready(res_ready),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .clear_mask(clear_mask),
        .retire_valid(retire_valid), .retire(retire), .retire_ready(retire_ready)
    );

    regfile #(.NUM_REGS(NUM_REGS), .N_READ_PORTS(3), .N_WRITE_PORTS(NUM_LANES)) u_rf (
        .clk(clk), .arst_n(arst_n),
        .rd_addr(rf_rd_addr), .rd_data(rf_rd_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

/* logic/isa_pkg.sv */
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SHL  = 4'd5,
        SHR  = 4'd6,
        ADDI = 4'd7,
        XORI = 4'd8
    } opcode_t;

    // register-register form
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [12:0] unused;
    } instr_r_t;

    // register-immediate form, imm is signed
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [17:0] imm;
    } instr_i_t;

    // opcode and rd line up in both views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    function automatic logic uses_imm(opcode_t op);
        return (op == ADDI) || (op == XORI);
    endfunction

    function automatic logic [xlen-1:0] alu_eval(opcode_t op, logic [xlen-1:0] a,
                                                 logic [xlen-1:0] b);
        logic [xlen-1:0] y;
        case (op)
            ADD, ADDI: y = a + b;
            SUB:       y = a - b;
            AND:       y = a & b;
            OR:        y = a | b;
            XOR, XORI: y = a ^ b;
            // shift amount from the low 5 bits only
            SHL:       y = a << b[4:0];
            SHR:       y = a >> b[4:0];
            default:   y = '0;
        endcase
        return y;
    endfunction

endpackage

/* logic/issue_unit.sv */
module issue_unit #(
    parameter int NUM_LANES = 2,
    parameter int NUM_REGS  = 32
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                in_valid,
    input  cluster_pkg::in_req_t                in_req,
    output logic                                in_ready,

    output isa_pkg::reg_idx_t [1:0]             rs_addr,
    input  logic [1:0][isa_pkg::xlen-1:0]       rs_data,

    output logic [NUM_LANES-1:0]                disp_valid,
    output cluster_pkg::dispatch_t              disp,
    input  logic [NUM_LANES-1:0]                disp_ready,

    input  logic [NUM_REGS-1:0]                 clear_mask
);

    isa_pkg::opcode_t          op;
    isa_pkg::reg_idx_t         rd;
    logic                      imm_form;
    logic [isa_pkg::xlen-1:0]  op_b;
    logic [NUM_REGS-1:0]       scoreboard;
    logic [NUM_REGS-1:0]       set_mask;
    // widened so any 5-bit index is safe
    logic [31:0]               sb_ext;
    logic [31:0]               clr_ext;
    logic                      src_busy;
    logic                      rd_busy;
    logic                      disp_free;
    logic [NUM_LANES-1:0]      lane_sel;
    logic                      started;
    logic                      accept;

    assign op       = in_req.instr.r.opcode;
    assign rd       = in_req.instr.r.rd;
    assign imm_form = isa_pkg::uses_imm(op);

    assign rs_addr[0] = in_req.instr.r.rs1;
    assign rs_addr[1] = in_req.instr.r.rs2;

    assign op_b = imm_form ? {{14{in_req.instr.i.imm[17]}}, in_req.instr.i.imm} : rs_data[1];

    assign sb_ext   = 32'(scoreboard);
    assign clr_ext  = 32'(clear_mask);
    assign src_busy = sb_ext[rs_addr[0]] || (!imm_form && sb_ext[rs_addr[1]]);
    assign rd_busy  = sb_ext[rd];

    // the held dispatch must leave before a new one is loaded
    assign disp_free = !(|disp_valid) || (|(disp_valid & disp_ready));

    // lowest set bit
    assign lane_sel = disp_ready & (~disp_ready + NUM_LANES'(1));

    assign in_ready = started && !src_busy && !rd_busy && (|disp_ready) && disp_free;
    assign accept   = in_valid && in_ready;

    always_comb begin
        for (int r = 0; r < NUM_REGS; r++) begin
            set_mask[r] = accept && (rd == isa_pkg::reg_idx_t'(r));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started    <= 1'b0;
            scoreboard <= '0;
            disp_valid <= '0;
        end else begin
            started    <= 1'b1;
            scoreboard <= (scoreboard & ~clear_mask) | set_mask;
            if (accept) begin
                disp_valid <= lane_sel;
            end else if (|(disp_valid & disp_ready)) begin
                disp_valid <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp <= '{op: op, rd: rd, tag: in_req.tag, a: rs_data[0], b: op_b};
        end
    end

    // a source written back on the accept edge would be read stale
    a_src_clear: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> !clr_ext[rs_addr[0]] && (imm_form || !clr_ext[rs_addr[1]]));

endmodule

/* logic/regfile.sv */
module regfile #(
    parameter int NUM_REGS      = 32,
    parameter int N_READ_PORTS  = 3,
    parameter int N_WRITE_PORTS = 2
) (
    input  logic                                          clk,
    input  logic                                          arst_n,

    input  isa_pkg::reg_idx_t [N_READ_PORTS-1:0]          rd_addr,
    output logic [N_READ_PORTS-1:0][isa_pkg::xlen-1:0]    rd_data,

    input  logic [N_WRITE_PORTS-1:0]                      wr_en,
    input  isa_pkg::reg_idx_t [N_WRITE_PORTS-1:0]         wr_addr,
    input  logic [N_WRITE_PORTS-1:0][isa_pkg::xlen-1:0]   wr_data
);

    logic [NUM_REGS-1:0][isa_pkg::xlen-1:0]  mem;
    logic [NUM_REGS-1:0][N_WRITE_PORTS-1:0]  we_pre;
    logic [NUM_REGS-1:0]                     we;
    logic [NUM_REGS-1:0][isa_pkg::xlen-1:0]  din;

    // per entry write enable from every port
    always_comb begin
        for (int e = 0; e < NUM_REGS; e++) begin
            for (int p = 0; p < N_WRITE_PORTS; p++) begin
                we_pre[e][p] = wr_en[p] && (wr_addr[p] == isa_pkg::reg_idx_t'(e));
            end
            we[e] = |we_pre[e];
        end
    end

    // walk ports from the top so the lowest enabled one wins
    always_comb begin
        for (int e = 0; e < NUM_REGS; e++) begin
            din[e] = '0;
            for (int p = N_WRITE_PORTS - 1; p >= 0; p--) begin
                if (we_pre[e][p]) begin
                    din[e] = wr_data[p];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem <= '0;
        end else begin
            for (int e = 0; e < NUM_REGS; e++) begin
                if (we[e]) begin
                    mem[e] <= din[e];
                end
            end
        end
    end

    // indices past NUM_REGS read as zero
    always_comb begin
        for (int r = 0; r < N_READ_PORTS; r++) begin
            rd_data[r] = (32'(rd_addr[r]) < NUM_REGS) ? mem[rd_addr[r]] : '0;
        end
    end

    // writeback relies on issue never having two rd in flight to one register
    for (genvar i = 0; i < N_WRITE_PORTS; i++) begin : g_wr_chk
        for (genvar j = i + 1; j < N_WRITE_PORTS; j++) begin : g_pair
            a_distinct_wr: assert property (@(posedge clk) disable iff (!arst_n)
                wr_en[i] && wr_en[j] |-> wr_addr[i] != wr_addr[j]);
        end
    end

endmodule

/* logic/writeback_unit.sv */
module writeback_unit #(
    parameter int NUM_LANES = 2,
    parameter int NUM_REGS  = 32
) (
    input  logic                                         clk,
    input  logic                                         arst_n,

    input  logic [NUM_LANES-1:0]                         res_valid,
    input  cluster_pkg::lane_result_t [NUM_LANES-1:0]    res,
    output logic [NUM_LANES-1:0]                         res_ready,

    output logic [NUM_LANES-1:0]                         wr_en,
    output isa_pkg::reg_idx_t [NUM_LANES-1:0]            wr_addr,
    output logic [NUM_LANES-1:0][isa_pkg::xlen-1:0]      wr_data,

    output logic [NUM_REGS-1:0]                          clear_mask,

    output logic                                         retire_valid,
    output cluster_pkg::retire_entry_t [NUM_LANES-1:0]   retire,
    input  logic                                         retire_ready
);

    logic fire;

    assign retire_valid = |res_valid;
    assign fire         = retire_valid && retire_ready;

    // one ready for all lanes, so the bundle moves as a whole
    assign res_ready = {NUM_LANES{retire_ready}};

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            retire[i].valid = res_valid[i];
            retire[i].rd    = res[i].rd;
            retire[i].tag   = res[i].tag;
            retire[i].value = res[i].value;
        end
    end

    // writes only on the accept edge
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_en[i]   = fire && res_valid[i];
            wr_addr[i] = res[i].rd;
            wr_data[i] = res[i].value;
        end
    end

    always_comb begin
        clear_mask = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (wr_en[i] && (res[i].rd == isa_pkg::reg_idx_t'(r))) begin
                    clear_mask[r] = 1'b1;
                end
            end
        end
    end

    // scoreboard upstream keeps one writer per register in flight
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_rd_chk
        for (genvar j = i + 1; j < NUM_LANES; j++) begin : g_pair
            a_rd_unique: assert property (@(posedge clk) disable iff (!arst_n)
                res_valid[i] && res_valid[j] |-> res[i].rd != res[j].rd);
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f int_cluster.f --top-module int_cluster_tb \
    -o int_cluster_sim \
    && ./obj_dir/int_cluster_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^Everything OK$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
